//--- hw/ce_pkg.sv
// FIFO depth must be a power of two that fits CE_FIFO_CNT_W; all widths are fixed
package ce_pkg;

   // --------------------------------------------------
   // Bus and data types
   // --------------------------------------------------
   typedef logic [31:0] ce_addr_t;
   typedef logic [63:0] ce_beat_t;
   typedef logic [15:0] ce_beats_t;
   typedef logic [31:0] ce_reg_t;
   typedef logic [2:0]  ce_reg_idx_t;

   // --------------------------------------------------
   // Engine constants
   // --------------------------------------------------
   localparam int CE_BEAT_BYTES = 8;
   localparam int CE_REQ_LIMIT  = 4;
   localparam int CE_REQ_W      = $clog2(CE_REQ_LIMIT + 1);
   localparam int CE_FIFO_DEPTH = 8;
   localparam int CE_FIFO_CNT_W = 4;
   localparam int CE_FIFO_PTR_W = $clog2(CE_FIFO_DEPTH);
   // Room for occupancy plus reservation plus next request
   localparam int CE_RES_W      = CE_FIFO_CNT_W + 1;
   localparam int CE_RST_STAGES = 4;

   localparam ce_reg_t CE_ID_VALUE = 32'hce01_0001;

   // --------------------------------------------------
   // Register map
   // --------------------------------------------------
   localparam ce_reg_idx_t CE_REG_ID     = 3'd0;
   localparam ce_reg_idx_t CE_REG_SRC    = 3'd1;
   localparam ce_reg_idx_t CE_REG_DST    = 3'd2;
   localparam ce_reg_idx_t CE_REG_SIZE   = 3'd3;
   localparam ce_reg_idx_t CE_REG_CTRL   = 3'd4;
   localparam ce_reg_idx_t CE_REG_STATUS = 3'd5;

   // CTRL bits, both self-clearing
   localparam int CE_CTRL_START    = 0;
   localparam int CE_CTRL_SOFT_RST = 1;

   // STATUS bits
   localparam int CE_ST_BUSY    = 0;
   localparam int CE_ST_DONE    = 1;
   localparam int CE_ST_CPL_ERR = 2;
   localparam int CE_ST_WR_ERR  = 3;

endpackage

//--- hw/ce_cfg_if.sv
`timescale 1ns/1ps
// Configuration comes from the register block and stays fixed while the engine is busy
interface ce_cfg_if
   import ce_pkg::*;
(
   input logic clk
);

   // Written by the register block
   ce_addr_t  src_addr;
   ce_addr_t  dst_addr;
   ce_beats_t xfer_beats;
   logic      start;
   logic      abort;

   // Status pulses back from the write side
   logic      wr_done;
   logic      wr_err;

   modport csr (output src_addr, dst_addr, xfer_beats, start, abort,
                input  wr_done, wr_err);
   modport rd  (input  src_addr, xfer_beats, start, abort);
   modport wr  (input  dst_addr, xfer_beats, start, abort,
                output wr_done, wr_err);

   // Busy must block a second start right behind the first
   a_start_pulse : assert property (@(posedge clk) start |=> !start);

endinterface

//--- hw/ce_csr.sv
`timescale 1ns/1ps
// Config writes are ignored while busy; after an error, soft reset before the next copy
module ce_csr
   import ce_pkg::*;
(
   input  logic        clk,
   input  logic        arst_n,
   input  logic        reg_cyc,
   input  logic        reg_stb,
   input  logic        reg_we,
   input  ce_reg_idx_t reg_adr,
   input  ce_reg_t     reg_dat_w,
   output ce_reg_t     reg_dat_r,
   output logic        reg_ack,
   input  logic        cpl_err,
   ce_cfg_if.csr       cfg,
   output logic        core_rst_n
);

   logic                     access;
   logic                     wr_en;
   logic                     rd_en;
   logic                     start_req;
   logic                     soft_rst;
   logic                     busy;
   logic                     done;
   logic                     cpl_err_flag;
   logic                     wr_err_flag;
   logic                     cpl_hit;
   logic                     err_now;
   logic [CE_RST_STAGES-1:0] rst_pipe;
   ce_reg_t                  rd_word;

   // --------------------------------------------------
   // Wishbone classic decode
   // --------------------------------------------------
   assign access    = reg_cyc & reg_stb & ~reg_ack;
   assign wr_en     = access & reg_we;
   assign rd_en     = access & ~reg_we;
   assign soft_rst  = wr_en & (reg_adr == CE_REG_CTRL) & reg_dat_w[CE_CTRL_SOFT_RST];
   assign start_req = wr_en & (reg_adr == CE_REG_CTRL) & reg_dat_w[CE_CTRL_START] & ~busy;

   always_comb begin
      rd_word = '0;
      case (reg_adr)
         CE_REG_ID:   rd_word = CE_ID_VALUE;
         CE_REG_SRC:  rd_word = cfg.src_addr;
         CE_REG_DST:  rd_word = cfg.dst_addr;
         CE_REG_SIZE: rd_word = ce_reg_t'(cfg.xfer_beats);
         CE_REG_STATUS: begin
            rd_word[CE_ST_BUSY]    = busy;
            rd_word[CE_ST_DONE]    = done;
            rd_word[CE_ST_CPL_ERR] = cpl_err_flag;
            rd_word[CE_ST_WR_ERR]  = wr_err_flag;
         end
         default: rd_word = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         reg_ack   <= 1'b0;
         reg_dat_r <= '0;
      end else begin
         reg_ack   <= access;
         reg_dat_r <= rd_en ? rd_word : '0;
      end
   end

   // Copy setup, untouched by soft reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cfg.src_addr   <= '0;
         cfg.dst_addr   <= '0;
         cfg.xfer_beats <= '0;
      end else if (wr_en && !busy) begin
         case (reg_adr)
            CE_REG_SRC:  cfg.src_addr   <= reg_dat_w;
            CE_REG_DST:  cfg.dst_addr   <= reg_dat_w;
            CE_REG_SIZE: cfg.xfer_beats <= ce_beats_t'(reg_dat_w);
            default: ;
         endcase
      end
   end

   // --------------------------------------------------
   // Status and start pulse
   // --------------------------------------------------
   assign cpl_hit   = busy & cpl_err;
   assign err_now   = cpl_hit | cfg.wr_err;
   // Engines stay stopped while any error bit is up
   assign cfg.abort = cpl_err_flag | wr_err_flag;

   always_ff @(posedge clk or negedge core_rst_n) begin
      if (!core_rst_n) begin
         cfg.start    <= 1'b0;
         busy         <= 1'b0;
         done         <= 1'b0;
         cpl_err_flag <= 1'b0;
         wr_err_flag  <= 1'b0;
      end else begin
         cfg.start <= start_req;
         if (cfg.start) begin
            busy         <= 1'b1;
            done         <= 1'b0;
            cpl_err_flag <= 1'b0;
            wr_err_flag  <= 1'b0;
         end else begin
            if (cfg.wr_done && !err_now) begin
               busy <= 1'b0;
               done <= 1'b1;
            end
            if (cpl_hit) begin
               busy         <= 1'b0;
               cpl_err_flag <= 1'b1;
            end
            if (cfg.wr_err) begin
               busy        <= 1'b0;
               wr_err_flag <= 1'b1;
            end
         end
      end
   end

   // --------------------------------------------------
   // Core reset stretch
   // --------------------------------------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rst_pipe <= '0;
      end else if (soft_rst) begin
         rst_pipe <= '0;
      end else begin
         rst_pipe <= {rst_pipe[CE_RST_STAGES-2:0], 1'b1};
      end
   end

   assign core_rst_n = rst_pipe[CE_RST_STAGES-1];

   a_ack_single : assert property (@(posedge clk) disable iff (!arst_n)
      reg_ack |=> !reg_ack);

endmodule

//--- hw/ce_rd_req.sv
`timescale 1ns/1ps
// One request held on the port at a time; completions must return in request order
module ce_rd_req
   import ce_pkg::*;
(
   input  logic                     clk,
   input  logic                     core_rst_n,
   ce_cfg_if.rd                     cfg,
   output logic                     rd_req_valid,
   input  logic                     rd_req_ready,
   output ce_addr_t                 rd_req_addr,
   output logic [CE_REQ_W-1:0]      rd_req_beats,
   input  logic                     cpl_valid,
   input  logic [CE_FIFO_CNT_W-1:0] fifo_count,
   input  logic                     fifo_pop
);

   ce_addr_t                 next_addr;
   ce_beats_t                remain;
   logic [CE_FIFO_CNT_W-1:0] pending;
   logic [CE_FIFO_CNT_W-1:0] pending_nxt;
   logic [CE_REQ_W-1:0]      next_beats;
   logic [CE_RES_W-1:0]      need;
   logic                     room;
   logic                     issue;

   assign next_beats = (remain > ce_beats_t'(CE_REQ_LIMIT)) ? CE_REQ_W'(CE_REQ_LIMIT)
                                                            : CE_REQ_W'(remain);

   // A beat popped this cycle already frees its slot
   assign need = CE_RES_W'(fifo_count) - CE_RES_W'(fifo_pop)
               + CE_RES_W'(pending) + CE_RES_W'(next_beats);
   assign room  = (need <= CE_RES_W'(CE_FIFO_DEPTH));
   assign issue = !rd_req_valid && (remain != '0) && room && !cfg.start && !cfg.abort;

   // Beats requested but not yet returned
   always_comb begin
      pending_nxt = pending;
      if (rd_req_valid && rd_req_ready) begin
         pending_nxt = pending_nxt + CE_FIFO_CNT_W'(rd_req_beats);
      end
      if (cpl_valid && pending_nxt != '0) begin
         pending_nxt = pending_nxt - 1'b1;
      end
   end

   always_ff @(posedge clk or negedge core_rst_n) begin
      if (!core_rst_n) begin
         rd_req_valid <= 1'b0;
         remain       <= '0;
         pending      <= '0;
      end else begin
         pending <= pending_nxt;
         if (cfg.start) begin
            remain       <= cfg.xfer_beats;
            rd_req_valid <= 1'b0;
         end else if (cfg.abort) begin
            remain       <= '0;
            rd_req_valid <= 1'b0;
         end else if (rd_req_valid) begin
            if (rd_req_ready) rd_req_valid <= 1'b0;
         end else if (issue) begin
            rd_req_valid <= 1'b1;
            remain       <= remain - ce_beats_t'(next_beats);
         end
      end
   end

   // Request payload and source walk
   always_ff @(posedge clk) begin
      if (cfg.start) begin
         next_addr <= cfg.src_addr;
      end else if (issue) begin
         next_addr <= next_addr + ce_addr_t'(next_beats) * ce_addr_t'(CE_BEAT_BYTES);
      end
      if (issue) begin
         rd_req_addr  <= next_addr;
         rd_req_beats <= next_beats;
      end
   end

   a_req_hold : assert property (@(posedge clk) disable iff (!core_rst_n)
      rd_req_valid && !rd_req_ready && !cfg.abort
         |=> rd_req_valid && $stable(rd_req_addr) && $stable(rd_req_beats));

endmodule

//--- hw/ce_cpl_fifo.sv
`timescale 1ns/1ps
// Depth must be a power of two; a push while full is dropped and sets a sticky overflow
module ce_cpl_fifo
   import ce_pkg::*;
(
   input  logic                     clk,
   input  logic                     core_rst_n,
   input  logic                     push,
   input  ce_beat_t                 push_data,
   input  logic                     pop,
   output ce_beat_t                 pop_data,
   output logic [CE_FIFO_CNT_W-1:0] count,
   output logic                     not_empty,
   output logic                     overflow
);

   ce_beat_t                 mem [CE_FIFO_DEPTH];
   logic [CE_FIFO_PTR_W-1:0] wr_ptr;
   logic [CE_FIFO_PTR_W-1:0] rd_ptr;
   logic                     full;
   logic                     push_ok;
   logic                     pop_ok;

   assign full      = (count == CE_FIFO_CNT_W'(CE_FIFO_DEPTH));
   assign not_empty = (count != '0);
   assign push_ok   = push & ~full;
   assign pop_ok    = pop & not_empty;
   assign pop_data  = mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (push_ok) mem[wr_ptr] <= push_data;
   end

   always_ff @(posedge clk or negedge core_rst_n) begin
      if (!core_rst_n) begin
         wr_ptr   <= '0;
         rd_ptr   <= '0;
         count    <= '0;
         overflow <= 1'b0;
      end else begin
         if (push_ok) wr_ptr <= wr_ptr + 1'b1;
         if (pop_ok)  rd_ptr <= rd_ptr + 1'b1;
         count <= count + CE_FIFO_CNT_W'(push_ok) - CE_FIFO_CNT_W'(pop_ok);
         if (push && full) overflow <= 1'b1;
      end
   end

   // Read reservation upstream must keep completions from hitting a full FIFO
   a_no_overflow : assert property (@(posedge clk) disable iff (!core_rst_n)
      push |-> !full);

endmodule

//--- hw/ce_wr_ctl.sv
`timescale 1ns/1ps
// One write outstanding; a response is only seen in a cycle after wr_ready
module ce_wr_ctl
   import ce_pkg::*;
(
   input  logic     clk,
   input  logic     core_rst_n,
   ce_cfg_if.wr     cfg,
   input  logic     fifo_not_empty,
   output logic     fifo_pop,
   input  ce_beat_t fifo_data,
   output logic     wr_valid,
   input  logic     wr_ready,
   output ce_addr_t wr_addr,
   output ce_beat_t wr_data,
   input  logic     wr_resp_valid,
   input  logic     wr_resp_err
);

   logic      active;
   logic      resp_wait;
   ce_beats_t resp_cnt;
   ce_beats_t resp_next;
   ce_addr_t  next_addr;

   assign resp_next = resp_cnt + 1'b1;

   // Load the write register straight from the FIFO head
   assign fifo_pop = active && !wr_valid && !resp_wait && fifo_not_empty
                     && !cfg.start && !cfg.abort;

   always_ff @(posedge clk or negedge core_rst_n) begin
      if (!core_rst_n) begin
         active      <= 1'b0;
         resp_wait   <= 1'b0;
         resp_cnt    <= '0;
         wr_valid    <= 1'b0;
         cfg.wr_done <= 1'b0;
         cfg.wr_err  <= 1'b0;
      end else begin
         cfg.wr_done <= 1'b0;
         cfg.wr_err  <= 1'b0;
         if (cfg.start) begin
            // Zero-beat copy finishes at once
            active      <= (cfg.xfer_beats != '0);
            cfg.wr_done <= (cfg.xfer_beats == '0);
            resp_cnt    <= '0;
            resp_wait   <= 1'b0;
            wr_valid    <= 1'b0;
         end else if (cfg.abort) begin
            active    <= 1'b0;
            resp_wait <= 1'b0;
            wr_valid  <= 1'b0;
         end else begin
            if (fifo_pop) wr_valid <= 1'b1;
            if (wr_valid && wr_ready) begin
               wr_valid  <= 1'b0;
               resp_wait <= 1'b1;
            end
            if (resp_wait && wr_resp_valid) begin
               resp_wait <= 1'b0;
               if (wr_resp_err) begin
                  active     <= 1'b0;
                  cfg.wr_err <= 1'b1;
               end else begin
                  resp_cnt <= resp_next;
                  if (resp_next == cfg.xfer_beats) begin
                     active      <= 1'b0;
                     cfg.wr_done <= 1'b1;
                  end
               end
            end
         end
      end
   end

   // Write payload and destination walk
   always_ff @(posedge clk) begin
      if (cfg.start) begin
         next_addr <= cfg.dst_addr;
      end else if (fifo_pop) begin
         next_addr <= next_addr + ce_addr_t'(CE_BEAT_BYTES);
      end
      if (fifo_pop) begin
         wr_addr <= next_addr;
         wr_data <= fifo_data;
      end
   end

   a_wr_hold : assert property (@(posedge clk) disable iff (!core_rst_n)
      wr_valid && !wr_ready && !cfg.abort
         |=> wr_valid && $stable(wr_addr) && $stable(wr_data));

endmodule

//--- hw/ce_top.sv
`timescale 1ns/1ps
// Single clock; completions have no back-pressure and rely on the read reservation
module ce_top
   import ce_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   // Wishbone register port
   input  logic                reg_cyc,
   input  logic                reg_stb,
   input  logic                reg_we,
   input  ce_reg_idx_t         reg_adr,
   input  ce_reg_t             reg_dat_w,
   output ce_reg_t             reg_dat_r,
   output logic                reg_ack,
   // Read requests
   output logic                rd_req_valid,
   output ce_addr_t            rd_req_addr,
   output logic [CE_REQ_W-1:0] rd_req_beats,
   input  logic                rd_req_ready,
   // Completions
   input  logic                cpl_valid,
   input  ce_beat_t            cpl_data,
   input  logic                cpl_err,
   // Destination writes
   output logic                wr_valid,
   output ce_addr_t            wr_addr,
   output ce_beat_t            wr_data,
   input  logic                wr_ready,
   input  logic                wr_resp_valid,
   input  logic                wr_resp_err
);

   logic                     core_rst_n;
   logic                     cpl_fault;
   logic                     fifo_pop;
   logic                     fifo_not_empty;
   logic                     fifo_overflow;
   logic [CE_FIFO_CNT_W-1:0] fifo_count;
   ce_beat_t                 fifo_data;

   ce_cfg_if i_cfg (.clk(clk));

   // A lost completion counts the same as a bad one
   assign cpl_fault = (cpl_valid & cpl_err) | fifo_overflow;

   ce_csr i_csr (
      .clk        (clk),
      .arst_n     (arst_n),
      .reg_cyc    (reg_cyc),
      .reg_stb    (reg_stb),
      .reg_we     (reg_we),
      .reg_adr    (reg_adr),
      .reg_dat_w  (reg_dat_w),
      .reg_dat_r  (reg_dat_r),
      .reg_ack    (reg_ack),
      .cpl_err    (cpl_fault),
      .cfg        (i_cfg.csr),
      .core_rst_n (core_rst_n)
   );

   ce_rd_req i_rd_req (
      .clk          (clk),
      .core_rst_n   (core_rst_n),
      .cfg          (i_cfg.rd),
      .rd_req_valid (rd_req_valid),
      .rd_req_ready (rd_req_ready),
      .rd_req_addr  (rd_req_addr),
      .rd_req_beats (rd_req_beats),
      .cpl_valid    (cpl_valid),
      .fifo_count   (fifo_count),
      .fifo_pop     (fifo_pop)
   );

   ce_cpl_fifo i_cpl_fifo (
      .clk        (clk),
      .core_rst_n (core_rst_n),
      .push       (cpl_valid),
      .push_data  (cpl_data),
      .pop        (fifo_pop),
      .pop_data   (fifo_data),
      .count      (fifo_count),
      .not_empty  (fifo_not_empty),
      .overflow   (fifo_overflow)
   );

   ce_wr_ctl i_wr_ctl (
      .clk            (clk),
      .core_rst_n     (core_rst_n),
      .cfg            (i_cfg.wr),
      .fifo_not_empty (fifo_not_empty),
      .fifo_pop       (fifo_pop),
      .fifo_data      (fifo_data),
      .wr_valid       (wr_valid),
      .wr_ready       (wr_ready),
      .wr_addr        (wr_addr),
      .wr_data        (wr_data),
      .wr_resp_valid  (wr_resp_valid),
      .wr_resp_err    (wr_resp_err)
   );

endmodule

//--- sim/ce_clk_gen.sv
`timescale 1ns/1ps
// Fixed 100 ns clock; arst_n is released on a falling edge after 16 rising edges
module ce_clk_gen (
   output logic clk,
   output logic arst_n
);

   localparam int HALF_PERIOD = 50;
   localparam int RST_CYCLES  = 16;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      // Release away from the rising edge
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

//--- sim/ce_host_model.sv
`timescale 1ns/1ps
// Completions return in request order; write responses never carry an error
module ce_host_model
   import ce_pkg::*;
(
   input  logic                clk,
   input  logic                arst_n,
   input  logic                err_arm,
   output logic                idle = 1'b1,
   input  logic                rd_req_valid,
   input  ce_addr_t            rd_req_addr,
   input  logic [CE_REQ_W-1:0] rd_req_beats,
   output logic                rd_req_ready = 1'b0,
   output logic                cpl_valid = 1'b0,
   output ce_beat_t            cpl_data = '0,
   output logic                cpl_err = 1'b0,
   input  logic                wr_valid,
   output logic                wr_ready = 1'b0,
   output logic                wr_resp_valid = 1'b0,
   output logic                wr_resp_err = 1'b0
);

   ce_addr_t beat_q[$];
   int       cpl_gap;
   int       resp_delay;
   logic     resp_pend;
   int       i;

   // Source memory content, a function of the whole byte address
   function automatic ce_beat_t source_word(ce_addr_t addr);
      return {addr ^ 32'ha5c3_0f96, ~addr + 32'h0101_0101};
   endfunction

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_req_ready  <= 1'b0;
         cpl_valid     <= 1'b0;
         cpl_err       <= 1'b0;
         wr_ready      <= 1'b0;
         wr_resp_valid <= 1'b0;
         wr_resp_err   <= 1'b0;
         idle          <= 1'b1;
         beat_q.delete();
         cpl_gap    = 0;
         resp_delay = 0;
         resp_pend  = 1'b0;
      end else begin
         rd_req_ready <= ($urandom_range(3) != 0);
         wr_ready     <= ($urandom_range(3) != 0);

         // ----------------------------------------------
         // Read side
         // ----------------------------------------------
         if (rd_req_valid && rd_req_ready) begin
            for (i = 0; i < int'(rd_req_beats); i++) begin
               beat_q.push_back(rd_req_addr + ce_addr_t'(i * CE_BEAT_BYTES));
            end
         end
         cpl_valid <= 1'b0;
         cpl_err   <= 1'b0;
         if (cpl_gap > 0) begin
            cpl_gap--;
         end else if (beat_q.size() != 0) begin
            cpl_valid <= 1'b1;
            cpl_data  <= source_word(beat_q.pop_front());
            cpl_err   <= err_arm;
            cpl_gap = $urandom_range(2);
         end

         // ----------------------------------------------
         // Write side
         // ----------------------------------------------
         wr_resp_valid <= 1'b0;
         if (resp_pend) begin
            if (resp_delay == 0) begin
               wr_resp_valid <= 1'b1;
               resp_pend = 1'b0;
            end else begin
               resp_delay--;
            end
         end
         if (wr_valid && wr_ready) begin
            resp_pend  = 1'b1;
            resp_delay = $urandom_range(3);
         end
         idle <= (beat_q.size() == 0) && !resp_pend;
      end
   end

endmodule

//--- sim/tb_ce_top.sv
`timescale 1ns/1ps
// Source data comes from the host model pattern; every wait is bounded by its own limit
module tb_ce_top;
   import ce_pkg::*;

   localparam int       SEED_VALUE  = 32'h6b17_11db;
   localparam int       REG_TIMEOUT = 8;
   localparam int       POLL_LIMIT  = 300;
   localparam int       IDLE_LIMIT  = 300;
   localparam int       RESET_LIMIT = 40;
   localparam int       COPY_BEATS  = 13;
   localparam ce_addr_t SRC_A       = 32'h0001_0000;
   localparam ce_addr_t DST_A       = 32'h0004_0000;
   localparam ce_addr_t SRC_B       = 32'h0002_0100;
   localparam ce_addr_t DST_B       = 32'h0005_0800;

   logic                clk;
   logic                arst_n;
   logic                reg_cyc;
   logic                reg_stb;
   logic                reg_we;
   ce_reg_idx_t         reg_adr;
   ce_reg_t             reg_dat_w;
   ce_reg_t             reg_dat_r;
   logic                reg_ack;
   logic                rd_req_valid;
   ce_addr_t            rd_req_addr;
   logic [CE_REQ_W-1:0] rd_req_beats;
   logic                rd_req_ready;
   logic                cpl_valid;
   ce_beat_t            cpl_data;
   logic                cpl_err;
   logic                wr_valid;
   ce_addr_t            wr_addr;
   ce_beat_t            wr_data;
   logic                wr_ready;
   logic                wr_resp_valid;
   logic                wr_resp_err;
   logic                err_arm;
   logic                host_idle;

   int       reg_errors;
   int       write_errors;
   int       other_errors;
   int       beats_req;
   int       req_count;
   int       wr_count;
   ce_addr_t src_base;
   ce_addr_t dst_base;
   ce_addr_t wr_addr_exp;

   ce_clk_gen i_clk_gen (.clk(clk), .arst_n(arst_n));

   ce_top i_ce_top (.*);

   ce_host_model i_host (.idle(host_idle), .*);

   // --------------------------------------------------
   // Reference model
   // --------------------------------------------------
   // Destination offset maps back to the same offset in the source
   function automatic ce_beat_t expected_beat(ce_addr_t dst, ce_addr_t src0, ce_addr_t dst0);
      ce_addr_t src;
      src = src0 + (dst - dst0);
      return i_host.source_word(src);
   endfunction

   function automatic ce_reg_t status_word(logic busy, logic done, logic cpl_e, logic wr_e);
      ce_reg_t w;
      w                = '0;
      w[CE_ST_BUSY]    = busy;
      w[CE_ST_DONE]    = done;
      w[CE_ST_CPL_ERR] = cpl_e;
      w[CE_ST_WR_ERR]  = wr_e;
      return w;
   endfunction

   task automatic check_reg(input string name, input ce_reg_t got, input ce_reg_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         reg_errors++;
      end
   endtask

   task automatic check_beat(input string name, input ce_beat_t got, input ce_beat_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         write_errors++;
      end
   endtask

   task automatic check_addr(input string name, input ce_addr_t got, input ce_addr_t exp);
      if (got !== exp) begin
         $display("FAILED %s: got %h, expected %h", name, got, exp);
         write_errors++;
      end
   endtask

   // --------------------------------------------------
   // Wishbone host
   // --------------------------------------------------
   task automatic bus_cycle(input logic we, input ce_reg_idx_t adr, input ce_reg_t wdata,
                            output ce_reg_t rdata);
      int cycles;
      @(posedge clk);
      reg_cyc   <= 1'b1;
      reg_stb   <= 1'b1;
      reg_we    <= we;
      reg_adr   <= adr;
      reg_dat_w <= wdata;
      cycles = 0;
      // Half a cycle in, ack must still be low
      @(negedge clk);
      while (!reg_ack && cycles < REG_TIMEOUT) begin
         @(negedge clk);
         cycles++;
      end
      rdata = reg_dat_r;
      if (!reg_ack) begin
         $display("No acknowledge for register %0d within %0d cycles", adr, REG_TIMEOUT);
         other_errors++;
      end else if (cycles != 1) begin
         $display("Register %0d acknowledged after %0d cycles instead of one", adr, cycles);
         other_errors++;
      end
      @(posedge clk);
      reg_cyc <= 1'b0;
      reg_stb <= 1'b0;
      reg_we  <= 1'b0;
   endtask

   task automatic reg_write(input ce_reg_idx_t adr, input ce_reg_t data);
      ce_reg_t unused;
      bus_cycle(1'b1, adr, data, unused);
   endtask

   task automatic reg_read(input ce_reg_idx_t adr, output ce_reg_t data);
      bus_cycle(1'b0, adr, '0, data);
   endtask

   task automatic read_and_check(input string name, input ce_reg_idx_t adr, input ce_reg_t exp);
      ce_reg_t got;
      reg_read(adr, got);
      check_reg(name, got, exp);
   endtask

   // --------------------------------------------------
   // Bounded waits
   // --------------------------------------------------
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk);
   endtask

   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (!arst_n && cycles < RESET_LIMIT) begin
         @(posedge clk);
         cycles++;
      end
      if (!arst_n) begin
         $display("Reset was never released");
         other_errors++;
      end
      // Core reset is stretched past arst_n
      wait_cycles(CE_RST_STAGES + 2);
   endtask

   task automatic wait_not_busy(output ce_reg_t status);
      int polls;
      polls = 0;
      reg_read(CE_REG_STATUS, status);
      while (status[CE_ST_BUSY] && polls < POLL_LIMIT) begin
         reg_read(CE_REG_STATUS, status);
         polls++;
      end
      if (status[CE_ST_BUSY]) begin
         $display("Timed out waiting for the copy to stop");
         other_errors++;
      end
   endtask

   task automatic wait_host_idle();
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!host_idle && cycles < IDLE_LIMIT) begin
         @(negedge clk);
         cycles++;
      end
      if (!host_idle) begin
         $display("Host model still had traffic after %0d cycles", IDLE_LIMIT);
         other_errors++;
      end
   endtask

   task automatic start_copy(input ce_addr_t src, input ce_addr_t dst, input ce_beats_t beats);
      @(negedge clk);
      src_base  = src;
      dst_base  = dst;
      beats_req = 0;
      req_count = 0;
      wr_count  = 0;
      reg_write(CE_REG_SRC, src);
      reg_write(CE_REG_DST, dst);
      reg_write(CE_REG_SIZE, ce_reg_t'(beats));
      reg_write(CE_REG_CTRL, ce_reg_t'(1) << CE_CTRL_START);
   endtask

   // --------------------------------------------------
   // Bus monitor and write compare
   // --------------------------------------------------
   always @(posedge clk) begin
      if (rd_req_valid && rd_req_ready) begin
         // Requests walk the source in order, right behind the last one
         check_addr("rd_req_addr", rd_req_addr,
                    src_base + ce_addr_t'(beats_req * CE_BEAT_BYTES));
         req_count++;
         beats_req += int'(rd_req_beats);
         if (rd_req_beats == '0 || int'(rd_req_beats) > CE_REQ_LIMIT) begin
            $display("Read request asked for %0d beats, limit is %0d", rd_req_beats,
                     CE_REQ_LIMIT);
            other_errors++;
         end
      end
      if (wr_valid && wr_ready) begin
         wr_addr_exp = dst_base + ce_addr_t'(wr_count * CE_BEAT_BYTES);
         check_addr("wr_addr", wr_addr, wr_addr_exp);
         check_beat("wr_data", wr_data, expected_beat(wr_addr_exp, src_base, dst_base));
         wr_count++;
      end
      if (beats_req - wr_count > CE_FIFO_DEPTH + 1) begin
         $display("Beats in flight reached %0d, above the FIFO depth plus one",
                  beats_req - wr_count);
         other_errors++;
      end
   end

   // --------------------------------------------------
   // Stimulus
   // --------------------------------------------------
   initial begin
      ce_reg_t status;
      int      req_seen;
      void'($urandom(SEED_VALUE));
      reg_cyc      = 1'b0;
      reg_stb      = 1'b0;
      reg_we       = 1'b0;
      reg_adr      = '0;
      reg_dat_w    = '0;
      err_arm      = 1'b0;
      reg_errors   = 0;
      write_errors = 0;
      other_errors = 0;
      beats_req    = 0;
      req_count    = 0;
      wr_count     = 0;
      src_base     = '0;
      dst_base     = '0;
      wait_reset_release();

      // Identification and idle status
      read_and_check("ID", CE_REG_ID, CE_ID_VALUE);
      read_and_check("STATUS", CE_REG_STATUS, '0);

      // Configuration read back, ID and unmapped words fixed
      reg_write(CE_REG_SRC, SRC_A);
      reg_write(CE_REG_DST, DST_A);
      reg_write(CE_REG_SIZE, ce_reg_t'(COPY_BEATS));
      read_and_check("SRC", CE_REG_SRC, SRC_A);
      read_and_check("DST", CE_REG_DST, DST_A);
      read_and_check("SIZE", CE_REG_SIZE, ce_reg_t'(COPY_BEATS));
      reg_write(CE_REG_ID, 32'h1234_5678);
      read_and_check("ID after write", CE_REG_ID, CE_ID_VALUE);
      read_and_check("unmapped word", ce_reg_idx_t'(7), '0);

      // Clean copy under back-pressure
      start_copy(SRC_A, DST_A, ce_beats_t'(COPY_BEATS));
      read_and_check("STATUS after start", CE_REG_STATUS, status_word(1'b1, 1'b0, 1'b0, 1'b0));
      wait_not_busy(status);
      check_reg("STATUS at end of copy", status, status_word(1'b0, 1'b1, 1'b0, 1'b0));
      check_reg("beats written", ce_reg_t'(wr_count), ce_reg_t'(COPY_BEATS));
      check_reg("beats requested", ce_reg_t'(beats_req), ce_reg_t'(COPY_BEATS));
      wait_host_idle();

      // Completion error stops the engine
      @(posedge clk);
      err_arm <= 1'b1;
      start_copy(SRC_B, DST_B, ce_beats_t'(COPY_BEATS));
      wait_not_busy(status);
      check_reg("STATUS after completion error", status, status_word(1'b0, 1'b0, 1'b1, 1'b0));
      req_seen = req_count;
      wait_cycles(20);
      if (req_count != req_seen) begin
         $display("Read requests continued after the completion error");
         other_errors++;
      end
      wait_host_idle();
      @(posedge clk);
      err_arm <= 1'b0;
      reg_write(CE_REG_CTRL, ce_reg_t'(1) << CE_CTRL_SOFT_RST);
      read_and_check("STATUS after soft reset", CE_REG_STATUS, '0);
      read_and_check("SRC after soft reset", CE_REG_SRC, SRC_B);

      $display("Summary: %0d register errors, %0d write errors, %0d other errors",
               reg_errors, write_errors, other_errors);
      if (reg_errors + write_errors + other_errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

//--- ce_top.f
hw/ce_pkg.sv
hw/ce_cfg_if.sv
hw/ce_csr.sv
hw/ce_rd_req.sv
hw/ce_cpl_fifo.sv
hw/ce_wr_ctl.sv
hw/ce_top.sv
sim/ce_clk_gen.sv
sim/ce_host_model.sv
sim/tb_ce_top.sv

//--- Bender.yml
package:
  name: ce_top

sources:
  - hw/ce_pkg.sv
  - hw/ce_cfg_if.sv
  - hw/ce_csr.sv
  - hw/ce_rd_req.sv
  - hw/ce_cpl_fifo.sv
  - hw/ce_wr_ctl.sv
  - hw/ce_top.sv
  - target: simulation
    files:
      - sim/ce_clk_gen.sv
      - sim/ce_host_model.sv
      - sim/tb_ce_top.sv
